// File: src/cvt_pkg.sv
/* Shared definitions for the single-precision float/integer converter
   Widths, saturation values, pipeline payloads and the rounding decision */
`default_nettype none

package cvt_pkg;

  // ====================
  // Widths and constants
  // ====================
  localparam int XLEN      = 32;
  localparam int EXP_BITS  = 8;
  localparam int FRAC_BITS = 23;
  localparam int EXP_BIAS  = 127;

  localparam logic [XLEN-1:0] INT_MAX  = {1'b0, {(XLEN - 1) {1'b1}}};
  localparam logic [XLEN-1:0] INT_MIN  = {1'b1, {(XLEN - 1) {1'b0}}};
  localparam logic [XLEN-1:0] UINT_MAX = {XLEN{1'b1}};

  // ====================
  // Types
  // ====================
  typedef enum logic [1:0] {
    CVT_F2W,
    CVT_F2WU,
    CVT_W2F,
    CVT_WU2F
  } cvt_op_e;

  typedef enum logic [2:0] {
    RM_RNE = 3'd0,
    RM_RTZ = 3'd1,
    RM_RDN = 3'd2,
    RM_RUP = 3'd3,
    RM_RMM = 3'd4
  } rm_e;

  typedef struct packed {
    logic nv;
    logic nx;
  } fp_flags_t;

  typedef struct packed {
    cvt_op_e         op;
    rm_e             rm;
    logic [XLEN-1:0] fp_operand;
    logic [XLEN-1:0] int_operand;
  } cvt_req_t;

  typedef struct packed {
    logic [XLEN-1:0] int_result;
    logic [XLEN-1:0] fp_result;
    fp_flags_t       flags;
  } cvt_rsp_t;

  // Travels alongside every pipeline stage
  typedef struct packed {
    logic    valid;
    cvt_op_e op;
    rm_e     rm;
  } cvt_tag_t;

  // Float to int, aligned value ahead of rounding
  typedef struct packed {
    logic [XLEN-1:0] shifted;
    logic            round_bit;
    logic            sticky_bit;
    logic            inexact_pre;
    logic            force_valid;
    logic [XLEN-1:0] force_result;
    logic            force_nv;
    logic            sign;
    logic            is_unsigned;
  } f2i_s3_t;

  // Int to float, normalised fields ahead of rounding
  typedef struct packed {
    logic                 sign;
    logic [EXP_BITS-1:0]  exp;
    logic [FRAC_BITS-1:0] frac;
    logic                 round_bit;
    logic                 sticky_bit;
    logic                 zero;
  } i2f_s3_t;

  // Whether the truncated magnitude gets incremented
  function automatic logic fp_round_up(
    input rm_e  rm,
    input logic round_bit,
    input logic sticky_bit,
    input logic lsb,
    input logic sign
  );
    logic up;
    case (rm)
      RM_RNE:  up = round_bit & (sticky_bit | lsb);
      RM_RTZ:  up = 1'b0;
      RM_RDN:  up = sign & (round_bit | sticky_bit);
      RM_RUP:  up = ~sign & (round_bit | sticky_bit);
      RM_RMM:  up = round_bit;
      default: up = 1'b0;
    endcase
    return up;
  endfunction

endpackage

`default_nettype wire

// File: src/cvt_lzc.sv
/* Leading-zero counter for a 32-bit magnitude */
`timescale 1ns/100ps
`default_nettype none

module cvt_lzc (
  input  wire  [cvt_pkg::XLEN-1:0] i_value,
  output logic [5:0]               o_lzc,
  output logic                     o_zero
);

  // Highest set bit wins since it is visited last
  always_comb begin
    o_lzc = 6'd32;
    for (int i = 0; i < cvt_pkg::XLEN; i++) begin
      if (i_value[i]) begin
        o_lzc = 6'(cvt_pkg::XLEN - 1 - i);
      end
    end
  end

  assign o_zero = (i_value == '0);

endmodule

`default_nettype wire

// File: src/cvt_unpack.sv
/* Operand capture and decode
   Splits the float fields and forms the integer magnitude and its leading-zero count */
`timescale 1ns/100ps
`default_nettype none

module cvt_unpack (
  input  wire                      i_clk,
  input  wire                      i_rst,
  input  wire                      i_valid,
  input  wire  cvt_pkg::cvt_req_t  i_req,
  output cvt_pkg::cvt_tag_t        o_tag,
  output logic                     o_fp_sign,
  output logic                     o_fp_zero,
  output logic                     o_fp_inf,
  output logic                     o_fp_nan,
  output logic signed [9:0]        o_unbiased_exp,
  output logic [23:0]              o_mant,
  output logic [cvt_pkg::XLEN-1:0] o_abs_int,
  output logic                     o_int_sign,
  output logic [5:0]               o_int_lzc,
  output logic                     o_int_zero
);

  cvt_pkg::cvt_tag_t                tag1;
  cvt_pkg::cvt_tag_t                tag2;
  logic [cvt_pkg::XLEN-1:0]         fp1;
  logic [cvt_pkg::XLEN-1:0]         int1;
  logic [cvt_pkg::XLEN-1:0]         fp2;
  logic [cvt_pkg::XLEN-1:0]         abs2;
  logic                             isign2;
  logic                             int_neg;
  logic [cvt_pkg::EXP_BITS-1:0]     exp_field;
  logic [cvt_pkg::FRAC_BITS-1:0]    frac_field;
  logic [5:0]                       lzc;
  logic                             lzc_zero;

  // Only the signed int source is negated
  assign int_neg = (tag1.op == cvt_pkg::CVT_W2F) & int1[cvt_pkg::XLEN-1];

  assign exp_field  = fp2[cvt_pkg::FRAC_BITS +: cvt_pkg::EXP_BITS];
  assign frac_field = fp2[cvt_pkg::FRAC_BITS-1:0];

  cvt_lzc i_cvt_lzc (
    .i_value (abs2),
    .o_lzc   (lzc),
    .o_zero  (lzc_zero)
  );

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      tag1  <= '0;
      tag2  <= '0;
      o_tag <= '0;
    end else begin
      tag1.valid <= i_valid;
      tag1.op    <= i_req.op;
      tag1.rm    <= i_req.rm;
      tag2       <= tag1;
      o_tag      <= tag2;
    end
  end

  // ====================
  // Payload ranks
  // ====================
  always_ff @(posedge i_clk) begin
    fp1    <= i_req.fp_operand;
    int1   <= i_req.int_operand;
    fp2    <= fp1;
    abs2   <= int_neg ? -int1 : int1;
    isign2 <= int_neg;

    o_fp_sign <= fp2[cvt_pkg::XLEN-1];
    o_fp_zero <= (exp_field == '0) && (frac_field == '0);
    o_fp_inf  <= (exp_field == '1) && (frac_field == '0);
    o_fp_nan  <= (exp_field == '1) && (frac_field != '0);
    // Subnormals sit at the minimum exponent without the hidden bit
    o_unbiased_exp <= (exp_field == '0) ? 10'(1 - cvt_pkg::EXP_BIAS)
                                        : 10'($signed({2'b00, exp_field}) - cvt_pkg::EXP_BIAS);
    o_mant     <= {exp_field != '0, frac_field};
    o_abs_int  <= abs2;
    o_int_sign <= isign2;
    o_int_lzc  <= lzc;
    o_int_zero <= lzc_zero;
  end

endmodule

`default_nettype wire

// File: src/cvt_f2i_align.sv
/* Float to int alignment stage
   Resolves special operands and shifts the mantissa to integer position */
`timescale 1ns/100ps
`default_nettype none

module cvt_f2i_align (
  input  wire                     i_clk,
  input  wire                     i_rst,
  input  wire  cvt_pkg::cvt_tag_t i_tag,
  input  wire                     i_fp_sign,
  input  wire                     i_fp_zero,
  input  wire                     i_fp_inf,
  input  wire                     i_fp_nan,
  input  wire  signed [9:0]       i_unbiased_exp,
  input  wire  [23:0]             i_mant,
  output cvt_pkg::cvt_tag_t       o_tag,
  output cvt_pkg::f2i_s3_t        o_s3
);

  cvt_pkg::f2i_s3_t s3_d;
  logic             is_unsigned;
  logic [5:0]       shamt;
  logic [55:0]      ext;

  assign is_unsigned = (i_tag.op == cvt_pkg::CVT_F2WU);

  always_comb begin
    s3_d             = '0;
    s3_d.sign        = i_fp_sign;
    s3_d.is_unsigned = is_unsigned;
    shamt            = 6'd32;
    ext              = '0;
    if (i_fp_nan) begin
      s3_d.force_valid  = 1'b1;
      s3_d.force_nv     = 1'b1;
      s3_d.force_result = is_unsigned ? cvt_pkg::UINT_MAX : cvt_pkg::INT_MAX;
    end else if (i_fp_inf || (i_unbiased_exp > 10'sd31)) begin
      // Too large for either format, saturate toward the sign
      s3_d.force_valid = 1'b1;
      s3_d.force_nv    = 1'b1;
      if (i_fp_sign) begin
        s3_d.force_result = is_unsigned ? '0 : cvt_pkg::INT_MIN;
      end else begin
        s3_d.force_result = is_unsigned ? cvt_pkg::UINT_MAX : cvt_pkg::INT_MAX;
      end
    end else if (i_fp_zero) begin
      s3_d.force_valid = 1'b1;
    end else if (i_unbiased_exp < -10'sd1) begin
      // Below one half, everything lands in sticky
      s3_d.sticky_bit  = 1'b1;
      s3_d.inexact_pre = 1'b1;
    end else begin
      // Integer part above bit 24, round and sticky below
      shamt            = 6'(10'sd31 - i_unbiased_exp);
      ext              = {i_mant, {cvt_pkg::XLEN{1'b0}}} >> shamt;
      s3_d.shifted     = ext[55:24];
      s3_d.round_bit   = ext[23];
      s3_d.sticky_bit  = |ext[22:0];
      s3_d.inexact_pre = ext[23] | (|ext[22:0]);
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_tag <= '0;
    end else begin
      o_tag <= i_tag;
    end
  end

  always_ff @(posedge i_clk) begin
    o_s3 <= s3_d;
  end

endmodule

`default_nettype wire

// File: src/cvt_f2i_round.sv
/* Float to int rounding stage
   Adds the rounding increment, checks the target range and saturates */
`timescale 1ns/100ps
`default_nettype none

module cvt_f2i_round (
  input  wire                      i_clk,
  input  wire                      i_rst,
  input  wire  cvt_pkg::cvt_tag_t  i_tag,
  input  wire  cvt_pkg::f2i_s3_t   i_s3,
  output cvt_pkg::cvt_tag_t        o_tag,
  output logic [cvt_pkg::XLEN-1:0] o_int_result,
  output cvt_pkg::fp_flags_t       o_flags
);

  logic                     up;
  logic [cvt_pkg::XLEN:0]   sum;
  logic                     nv;
  logic [cvt_pkg::XLEN-1:0] res;

  always_comb begin
    up  = cvt_pkg::fp_round_up(i_tag.rm, i_s3.round_bit, i_s3.sticky_bit,
                               i_s3.shifted[0], i_s3.sign);
    sum = {1'b0, i_s3.shifted} + 33'(up);
    nv  = 1'b0;
    res = sum[cvt_pkg::XLEN-1:0];
    if (i_s3.force_valid) begin
      res = i_s3.force_result;
      nv  = i_s3.force_nv;
    end else if (i_s3.sign && i_s3.is_unsigned) begin
      // Any nonzero negative is out of range
      res = '0;
      nv  = (sum != '0);
    end else if (i_s3.sign) begin
      if (sum > {2'b01, 31'b0}) begin
        res = cvt_pkg::INT_MIN;
        nv  = 1'b1;
      end else begin
        res = -sum[cvt_pkg::XLEN-1:0];
      end
    end else if (i_s3.is_unsigned) begin
      if (sum[cvt_pkg::XLEN]) begin
        res = cvt_pkg::UINT_MAX;
        nv  = 1'b1;
      end
    end else if (sum > {2'b00, {31{1'b1}}}) begin
      res = cvt_pkg::INT_MAX;
      nv  = 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_tag <= '0;
    end else begin
      o_tag <= i_tag;
    end
  end

  always_ff @(posedge i_clk) begin
    o_int_result <= res;
    o_flags.nv   <= nv;
    o_flags.nx   <= i_s3.inexact_pre & ~nv;
  end

endmodule

`default_nettype wire

// File: src/cvt_i2f_norm.sv
/* Int to float conversion in two stages
   Normalises the magnitude, then rounds and packs the single-precision result */
`timescale 1ns/100ps
`default_nettype none

module cvt_i2f_norm (
  input  wire                      i_clk,
  input  wire                      i_rst,
  input  wire  cvt_pkg::rm_e       i_rm,
  input  wire  [cvt_pkg::XLEN-1:0] i_abs_int,
  input  wire                      i_int_sign,
  input  wire  [5:0]               i_int_lzc,
  input  wire                      i_int_zero,
  output logic [cvt_pkg::XLEN-1:0] o_fp_result,
  output logic                     o_nx
);

  logic [cvt_pkg::XLEN-1:0]    norm;
  cvt_pkg::i2f_s3_t            s3_d;
  cvt_pkg::i2f_s3_t            s3_q;
  cvt_pkg::rm_e                rm_q;
  logic                        up;
  logic [cvt_pkg::FRAC_BITS:0] frac_sum;
  logic [cvt_pkg::EXP_BITS-1:0] exp_rnd;

  // ====================
  // Stage one, normalise
  // ====================
  always_comb begin
    norm            = i_abs_int << i_int_lzc;
    s3_d.sign       = i_int_sign;
    s3_d.exp        = 8'(cvt_pkg::EXP_BIAS + cvt_pkg::XLEN - 1 - int'(i_int_lzc));
    // Leading one is the hidden bit and is dropped
    s3_d.frac       = norm[30:8];
    s3_d.round_bit  = norm[7];
    s3_d.sticky_bit = |norm[6:0];
    s3_d.zero       = i_int_zero;
  end

  always_ff @(posedge i_clk) begin
    s3_q <= s3_d;
    rm_q <= i_rm;
  end

  // ====================
  // Stage two, round and pack
  // ====================
  always_comb begin
    up       = cvt_pkg::fp_round_up(rm_q, s3_q.round_bit, s3_q.sticky_bit,
                                    s3_q.frac[0], s3_q.sign);
    frac_sum = {1'b0, s3_q.frac} + 24'(up);
    // Carry out leaves the low fraction bits at zero
    exp_rnd  = s3_q.exp + 8'(frac_sum[cvt_pkg::FRAC_BITS]);
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_fp_result <= '0;
      o_nx        <= 1'b0;
    end else begin
      o_fp_result <= s3_q.zero ? '0
                               : {s3_q.sign, exp_rnd, frac_sum[cvt_pkg::FRAC_BITS-1:0]};
      o_nx        <= s3_q.round_bit | s3_q.sticky_bit;
    end
  end

endmodule

`default_nettype wire

// File: src/cvt_result_sel.sv
/* Output stage, picks the integer or float result and registers the response */
`timescale 1ns/100ps
`default_nettype none

module cvt_result_sel (
  input  wire                      i_clk,
  input  wire                      i_rst,
  input  wire  cvt_pkg::cvt_tag_t  i_tag,
  input  wire  [cvt_pkg::XLEN-1:0] i_int_result,
  input  wire  cvt_pkg::fp_flags_t i_f2i_flags,
  input  wire  [cvt_pkg::XLEN-1:0] i_fp_result,
  input  wire                      i_i2f_nx,
  output logic                     o_valid,
  output cvt_pkg::cvt_rsp_t        o_rsp
);

  cvt_pkg::cvt_rsp_t rsp_d;

  // The unused result field stays zero
  always_comb begin
    rsp_d = '0;
    case (i_tag.op)
      cvt_pkg::CVT_F2W, cvt_pkg::CVT_F2WU: begin
        rsp_d.int_result = i_int_result;
        rsp_d.flags      = i_f2i_flags;
      end
      default: begin
        rsp_d.fp_result = i_fp_result;
        rsp_d.flags.nx  = i_i2f_nx;
      end
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_valid <= 1'b0;
    end else begin
      o_valid <= i_tag.valid;
    end
  end

  always_ff @(posedge i_clk) begin
    o_rsp <= rsp_d;
  end

endmodule

`default_nettype wire

// File: src/fp_cvt_top.sv
/* Pipelined single-precision float/integer converter
   One request per cycle, response five cycles later in issue order */
`timescale 1ns/100ps
`default_nettype none

module fp_cvt_top (
  input  wire                     i_clk,
  input  wire                     i_rst,
  input  wire                     i_valid,
  input  wire  cvt_pkg::cvt_req_t i_req,
  output logic                    o_valid,
  output cvt_pkg::cvt_rsp_t       o_rsp
);

  cvt_pkg::cvt_tag_t        s2_tag;
  logic                     s2_fp_sign;
  logic                     s2_fp_zero;
  logic                     s2_fp_inf;
  logic                     s2_fp_nan;
  logic signed [9:0]        s2_unbiased_exp;
  logic [23:0]              s2_mant;
  logic [cvt_pkg::XLEN-1:0] s2_abs_int;
  logic                     s2_int_sign;
  logic [5:0]               s2_int_lzc;
  logic                     s2_int_zero;
  cvt_pkg::cvt_tag_t        s3_tag;
  cvt_pkg::f2i_s3_t         s3_f2i;
  cvt_pkg::cvt_tag_t        s4_tag;
  logic [cvt_pkg::XLEN-1:0] s4_int_result;
  cvt_pkg::fp_flags_t       s4_f2i_flags;
  logic [cvt_pkg::XLEN-1:0] s4_fp_result;
  logic                     s4_i2f_nx;

  cvt_unpack i_cvt_unpack (
    .i_clk          (i_clk),
    .i_rst          (i_rst),
    .i_valid        (i_valid),
    .i_req          (i_req),
    .o_tag          (s2_tag),
    .o_fp_sign      (s2_fp_sign),
    .o_fp_zero      (s2_fp_zero),
    .o_fp_inf       (s2_fp_inf),
    .o_fp_nan       (s2_fp_nan),
    .o_unbiased_exp (s2_unbiased_exp),
    .o_mant         (s2_mant),
    .o_abs_int      (s2_abs_int),
    .o_int_sign     (s2_int_sign),
    .o_int_lzc      (s2_int_lzc),
    .o_int_zero     (s2_int_zero)
  );

  cvt_f2i_align i_cvt_f2i_align (
    .i_clk          (i_clk),
    .i_rst          (i_rst),
    .i_tag          (s2_tag),
    .i_fp_sign      (s2_fp_sign),
    .i_fp_zero      (s2_fp_zero),
    .i_fp_inf       (s2_fp_inf),
    .i_fp_nan       (s2_fp_nan),
    .i_unbiased_exp (s2_unbiased_exp),
    .i_mant         (s2_mant),
    .o_tag          (s3_tag),
    .o_s3           (s3_f2i)
  );

  cvt_f2i_round i_cvt_f2i_round (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_tag        (s3_tag),
    .i_s3         (s3_f2i),
    .o_tag        (s4_tag),
    .o_int_result (s4_int_result),
    .o_flags      (s4_f2i_flags)
  );

  // Int path keeps its own rounding mode copy, so it takes rm from the stage-2 tag
  cvt_i2f_norm i_cvt_i2f_norm (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_rm        (s2_tag.rm),
    .i_abs_int   (s2_abs_int),
    .i_int_sign  (s2_int_sign),
    .i_int_lzc   (s2_int_lzc),
    .i_int_zero  (s2_int_zero),
    .o_fp_result (s4_fp_result),
    .o_nx        (s4_i2f_nx)
  );

  cvt_result_sel i_cvt_result_sel (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_tag        (s4_tag),
    .i_int_result (s4_int_result),
    .i_f2i_flags  (s4_f2i_flags),
    .i_fp_result  (s4_fp_result),
    .i_i2f_nx     (s4_i2f_nx),
    .o_valid      (o_valid),
    .o_rsp        (o_rsp)
  );

endmodule

`default_nettype wire

// File: sim/tb_fp_cvt_model.svh
/* Reference model for the float/integer converter testbench
   Computes expected results and flags from the conversion rules */
`ifndef TB_FP_CVT_MODEL_SVH
`define TB_FP_CVT_MODEL_SVH

// Increment decision for a truncated magnitude, rm uses the RISC-V encoding
function automatic bit rounds_up(input int rm, input bit rnd, input bit stk,
                                 input bit lsb, input bit neg);
  case (rm)
    0: return rnd && (stk || lsb);
    1: return 1'b0;
    2: return neg && (rnd || stk);
    3: return !neg && (rnd || stk);
    4: return rnd;
    default: return 1'b0;
  endcase
endfunction

function automatic cvt_pkg::cvt_rsp_t float_to_int_model(input logic [31:0] f, input int rm,
                                                         input bit uns);
  cvt_pkg::cvt_rsp_t r;
  logic [63:0]       m;
  logic [63:0]       ip;
  logic [63:0]       mag;
  int                ebits;
  int                e;
  int                sh;
  bit                neg;
  bit                rnd;
  bit                stk;
  r     = '0;
  neg   = f[31];
  ebits = f[30:23];
  m     = {40'd0, ebits != 0, f[22:0]};
  if (ebits == 255 && f[22:0] != 0) begin
    r.flags.nv   = 1'b1;
    r.int_result = uns ? 32'hffffffff : 32'h7fffffff;
    return r;
  end
  if (f[30:0] == 0) begin
    return r;
  end
  e = (ebits == 0) ? -126 : ebits - 127;
  // Infinity lands here too with e = 128
  if (e > 31) begin
    r.flags.nv = 1'b1;
    if (neg) begin
      r.int_result = uns ? 32'h0 : 32'h80000000;
    end else begin
      r.int_result = uns ? 32'hffffffff : 32'h7fffffff;
    end
    return r;
  end
  if (e >= 23) begin
    ip  = m << (e - 23);
    rnd = 1'b0;
    stk = 1'b0;
  end else begin
    sh = 23 - e;
    if (sh > 60) begin
      ip  = '0;
      rnd = 1'b0;
      stk = 1'b1;
    end else begin
      ip  = m >> sh;
      rnd = m[sh-1];
      stk = (m & ((64'd1 << (sh - 1)) - 64'd1)) != 0;
    end
  end
  mag = ip + 64'(rounds_up(rm, rnd, stk, ip[0], neg));
  if (neg && uns) begin
    r.flags.nv   = (mag != 0);
    r.int_result = '0;
  end else if (neg) begin
    r.flags.nv   = (mag > 64'h80000000);
    r.int_result = r.flags.nv ? 32'h80000000 : 32'(64'd0 - mag);
  end else if (uns) begin
    r.flags.nv   = (mag > 64'hffffffff);
    r.int_result = r.flags.nv ? 32'hffffffff : mag[31:0];
  end else begin
    r.flags.nv   = (mag > 64'h7fffffff);
    r.int_result = r.flags.nv ? 32'h7fffffff : mag[31:0];
  end
  r.flags.nx = (rnd || stk) && !r.flags.nv;
  return r;
endfunction

function automatic cvt_pkg::cvt_rsp_t int_to_float_model(input logic [31:0] x, input int rm,
                                                         input bit sgn);
  cvt_pkg::cvt_rsp_t r;
  logic [63:0]       mag;
  logic [63:0]       keep;
  int                p;
  int                sh;
  int                ex;
  int                i;
  bit                neg;
  bit                rnd;
  bit                stk;
  r   = '0;
  neg = sgn && x[31];
  mag = neg ? {32'd0, 32'(-x)} : {32'd0, x};
  if (mag == 0) begin
    return r;
  end
  p = 0;
  for (i = 0; i < 32; i++) begin
    if (mag[i]) begin
      p = i;
    end
  end
  ex = 127 + p;
  if (p <= 23) begin
    keep = mag << (23 - p);
    rnd  = 1'b0;
    stk  = 1'b0;
  end else begin
    sh   = p - 23;
    keep = mag >> sh;
    rnd  = mag[sh-1];
    stk  = (mag & ((64'd1 << (sh - 1)) - 64'd1)) != 0;
  end
  keep = keep + 64'(rounds_up(rm, rnd, stk, keep[0], neg));
  // Mantissa overflow moves into the exponent
  if (keep[24]) begin
    keep = keep >> 1;
    ex   = ex + 1;
  end
  r.fp_result = {neg, 8'(ex), keep[22:0]};
  r.flags.nx  = rnd || stk;
  return r;
endfunction

function automatic cvt_pkg::cvt_rsp_t expected_response(input cvt_pkg::cvt_req_t req);
  case (req.op)
    cvt_pkg::CVT_F2W:  return float_to_int_model(req.fp_operand, int'(req.rm), 1'b0);
    cvt_pkg::CVT_F2WU: return float_to_int_model(req.fp_operand, int'(req.rm), 1'b1);
    cvt_pkg::CVT_W2F:  return int_to_float_model(req.int_operand, int'(req.rm), 1'b1);
    default:           return int_to_float_model(req.int_operand, int'(req.rm), 1'b0);
  endcase
endfunction

`endif

// File: sim/tb_fp_cvt.sv
/* Testbench for the pipelined float/integer converter
   Random and directed requests, scoreboard queue and latency checks */
`timescale 1ns/100ps
`default_nettype none

module tb_fp_cvt;

  logic              i_clk;
  logic              i_rst;
  logic              i_valid;
  cvt_pkg::cvt_req_t i_req;
  logic              o_valid;
  cvt_pkg::cvt_rsp_t o_rsp;

  cvt_pkg::cvt_req_t req_q[$];
  cvt_pkg::cvt_rsp_t exp_q[$];
  int unsigned       at_q[$];
  cvt_pkg::cvt_req_t head_req;
  cvt_pkg::cvt_rsp_t head_rsp;
  int unsigned       head_at;
  int unsigned       cycle_count = 0;
  int                errors = 0;
  int                checks = 0;
  logic [31:0]       lfsr_state = 32'ha88deaa9;

  logic [31:0] exact_ints [10] = '{32'h0, 32'h1, 32'hffffffff, 32'h7, 32'hffffff9c,
                                   32'h00100000, 32'h01000000, 32'h80000000,
                                   32'h00ffffff, 32'h40000000};
  logic [31:0] carry_ints [3]  = '{32'h01ffffff, 32'hffffffff, 32'h7fffffc0};
  logic [31:0] float_cases [25] = '{
    32'h3f800000, 32'h40200000, 32'hc0200000, 32'h3f000000, 32'hbf000000,
    32'h3fc00000, 32'h3e99999a, 32'hbe99999a, 32'h00000001, 32'h80400000,
    32'h4b7fffff, 32'h4effffff, 32'h3f400000, 32'hc2f6e979, 32'h80000000,
    32'h7fc00000, 32'h7f800000, 32'hff800000, 32'h4f000000, 32'hcf000000,
    32'h4f800000, 32'hcf000001, 32'h501502f9, 32'hbf800000, 32'h4f7fffff};

  `include "tb_fp_cvt_model.svh"

  fp_cvt_top i_fp_cvt_top (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_valid (i_valid),
    .i_req   (i_req),
    .o_valid (o_valid),
    .o_rsp   (o_rsp)
  );

  initial begin
    i_clk = 1'b0;
    forever #5 i_clk = ~i_clk;
  end

  always @(posedge i_clk) begin
    cycle_count <= cycle_count + 1;
  end

  // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] bits;
    logic        fb;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      bits       = {bits[30:0], fb};
    end
    return bits;
  endfunction

  task automatic issue(input cvt_pkg::cvt_op_e op, input cvt_pkg::rm_e rm,
                       input logic [31:0] fp_val, input logic [31:0] int_val);
    cvt_pkg::cvt_req_t req;
    req.op          = op;
    req.rm          = rm;
    req.fp_operand  = fp_val;
    req.int_operand = int_val;
    i_valid = 1'b1;
    i_req   = req;
    req_q.push_back(req);
    exp_q.push_back(expected_response(req));
    at_q.push_back(cycle_count + 1);
    @(negedge i_clk);
    i_valid = 1'b0;
  endtask

  task automatic idle(input int n);
    i_valid = 1'b0;
    repeat (n) @(negedge i_clk);
  endtask

  // ====================
  // Scoreboard
  // ====================
  always @(negedge i_clk) begin
    if (i_rst) begin
      assert (!o_valid) else begin
        errors++;
        $display("[ERROR] %0t: o_valid high during reset", $time);
      end
    end else if (o_valid) begin
      assert (exp_q.size() > 0) else begin
        errors++;
        $display("[ERROR] %0t: o_valid high with no request in flight", $time);
      end
      if (exp_q.size() > 0) begin
        head_req = req_q.pop_front();
        head_rsp = exp_q.pop_front();
        head_at  = at_q.pop_front();
        checks++;
        assert (cycle_count == head_at + 5) else begin
          errors++;
          $display("[ERROR] %0t: response at cycle %0d, expected cycle %0d",
                   $time, cycle_count, head_at + 5);
        end
        assert (o_rsp == head_rsp) else begin
          errors++;
          $display("[ERROR] %0t: op %0d rm %0d in %h/%h got %h/%h/%b exp %h/%h/%b",
                   $time, head_req.op, head_req.rm, head_req.fp_operand, head_req.int_operand,
                   o_rsp.int_result, o_rsp.fp_result, o_rsp.flags, head_rsp.int_result,
                   head_rsp.fp_result, head_rsp.flags);
        end
      end
    end else if (at_q.size() > 0) begin
      assert (cycle_count < at_q[0] + 5) else begin
        errors++;
        $display("[ERROR] %0t: response for the request of cycle %0d never arrived",
                 $time, at_q[0]);
        void'(req_q.pop_front());
        void'(exp_q.pop_front());
        void'(at_q.pop_front());
      end
    end
  end

  initial begin
    int wait_cycles;
    i_rst   = 1'b1;
    i_valid = 1'b0;
    i_req   = '0;
    repeat (8) @(posedge i_clk);
    @(negedge i_clk);
    i_rst = 1'b0;
    idle(4);

    // Exact and boundary integers in every mode
    for (int r = 0; r < 5; r++) begin
      foreach (exact_ints[i]) begin
        issue(cvt_pkg::CVT_W2F, cvt_pkg::rm_e'(r), ~exact_ints[i], exact_ints[i]);
        issue(cvt_pkg::CVT_WU2F, cvt_pkg::rm_e'(r), ~exact_ints[i], exact_ints[i]);
      end
      idle(2);
    end

    // Wide integers that need rounding plus mantissa carry cases
    for (int r = 0; r < 5; r++) begin
      foreach (carry_ints[i]) begin
        issue(cvt_pkg::CVT_W2F, cvt_pkg::rm_e'(r), 32'h0, carry_ints[i]);
        issue(cvt_pkg::CVT_WU2F, cvt_pkg::rm_e'(r), 32'h0, carry_ints[i]);
      end
      for (int n = 0; n < 12; n++) begin
        issue(take_bits(1) ? cvt_pkg::CVT_WU2F : cvt_pkg::CVT_W2F, cvt_pkg::rm_e'(r),
              32'h0, take_bits(32) | 32'h01000000);
        if (take_bits(2) == 0) begin
          idle(1);
        end
      end
    end

    // Directed floats in range and out of range
    foreach (float_cases[i]) begin
      for (int r = 0; r < 5; r++) begin
        issue(cvt_pkg::CVT_F2W, cvt_pkg::rm_e'(r), float_cases[i], 32'h0);
        issue(cvt_pkg::CVT_F2WU, cvt_pkg::rm_e'(r), float_cases[i], 32'h0);
      end
      if (i % 2 == 1) begin
        idle(1);
      end
    end

    // Random floats with exponents around the integer range
    for (int n = 0; n < 60; n++) begin
      issue(take_bits(1) ? cvt_pkg::CVT_F2WU : cvt_pkg::CVT_F2W,
            cvt_pkg::rm_e'(3'(take_bits(3) % 5)),
            {1'(take_bits(1)), 8'(110 + take_bits(5)), 23'(take_bits(23))}, 32'h0);
      if (take_bits(2) == 0) begin
        idle(1);
      end
    end

    for (wait_cycles = 0; wait_cycles < 20 && at_q.size() > 0; wait_cycles++) begin
      @(negedge i_clk);
    end
    if (at_q.size() > 0) begin
      errors++;
      $display("Timeout while draining, %0d responses still outstanding", at_q.size());
    end
    idle(3);
    $display("Checked %0d responses, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
+incdir+sim
src/cvt_pkg.sv
src/cvt_lzc.sv
src/cvt_unpack.sv
src/cvt_f2i_align.sv
src/cvt_f2i_round.sv
src/cvt_i2f_norm.sv
src/cvt_result_sel.sv
src/fp_cvt_top.sv
sim/tb_fp_cvt.sv
